/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and register file
`define XLEN      64
`define REG_COUNT 32

`define RESET_PC  64'h0
`define SP_INIT   64'h1000     // x2 after reset
`define EXIT_CALL 64'd93       // x17 value for exit ecall

// RV64I major opcodes
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_SYSTEM 7'b1110011

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_SLT  4'd5
`define ALU_SLTU 4'd6
`define ALU_SLL  4'd7
`define ALU_SRL  4'd8
`define ALU_SRA  4'd9

`endif

/* src/cpuPkg.sv */
`include "cpu_defs.svh"

package cpuPkg;

	// one data word
	typedef logic [`XLEN-1:0] xlen_t;

	typedef logic [31:0] instr_t;

	typedef logic [4:0] regIdx_t;

	// ALU operation, codes in cpu_defs.svh
	typedef logic [3:0] aluOp_t;

	typedef enum logic {
		RUN,
		HALTED
	} runState_t;

endpackage

/* src/fetchControl.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetchControl import cpuPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  branchTaken,
	input  xlen_t branchTarget,
	input  logic  exitCall,
	output xlen_t pc,
	output logic  halted,
	output xlen_t cycleCount
);

	runState_t state;
	xlen_t nextPc;

	assign nextPc = branchTaken ? branchTarget : pc + 64'd4;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= `RESET_PC;
			cycleCount <= '0;
			state <= RUN;
		end else if (state == RUN) begin
			pc <= nextPc;
			cycleCount <= cycleCount + 64'd1;    // counts the ecall too
			if (exitCall) begin
				state <= HALTED;
			end
		end
	end

	assign halted = (state == HALTED);

endmodule

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instrDecoder import cpuPkg::*; (
	input  instr_t instr,
	input  xlen_t  pc,
	input  xlen_t  rs1Value,
	input  xlen_t  rs2Value,
	input  xlen_t  callValue,
	input  logic   halted,
	output xlen_t  aluA,
	output xlen_t  aluB,
	output aluOp_t aluOp,
	output logic   regWrite,
	output logic   memRead,
	output logic   memWrite,
	output logic   branchTaken,
	output xlen_t  branchTarget,
	output logic   exitCall
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t iImm;
	xlen_t sImm;
	xlen_t bImm;
	xlen_t uImm;
	xlen_t jImm;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign iImm = {{52{instr[31]}}, instr[31:20]};
	assign sImm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign bImm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign uImm = {{32{instr[31]}}, instr[31:12], 12'b0};    // RV64 lui sign extends
	assign jImm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign branchTarget = pc + ((opcode == `OPC_JAL) ? jImm : bImm);

	always_comb begin
		aluA = rs1Value;
		aluB = rs2Value;
		aluOp = `ALU_ADD;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchTaken = 1'b0;
		exitCall = 1'b0;

		case (opcode)
			`OPC_OP: begin
				regWrite = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				case (funct3)
					3'b000: aluOp = funct7[5] ? `ALU_SUB : `ALU_ADD;
					3'b001: aluOp = `ALU_SLL;
					3'b010: aluOp = `ALU_SLT;
					3'b011: aluOp = `ALU_SLTU;
					3'b100: aluOp = `ALU_XOR;
					3'b101: aluOp = funct7[5] ? `ALU_SRA : `ALU_SRL;
					3'b110: aluOp = `ALU_OR;
					default: aluOp = `ALU_AND;
				endcase
			end
			`OPC_OPIMM: begin
				aluB = iImm;
				regWrite = 1'b1;
				case (funct3)
					3'b000: aluOp = `ALU_ADD;
					3'b010: aluOp = `ALU_SLT;
					3'b100: aluOp = `ALU_XOR;
					3'b110: aluOp = `ALU_OR;
					3'b111: aluOp = `ALU_AND;
					default: regWrite = 1'b0;    // no shift or sltiu forms
				endcase
			end
			`OPC_LUI: begin
				aluA = '0;
				aluB = uImm;
				regWrite = 1'b1;
			end
			`OPC_LOAD: begin
				aluB = iImm;
				regWrite = (funct3 == 3'b011);    // ld only
				memRead = (funct3 == 3'b011);
			end
			`OPC_STORE: begin
				aluB = sImm;
				memWrite = (funct3 == 3'b011);    // sd only
			end
			`OPC_BRANCH: begin
				case (funct3)
					3'b000: branchTaken = (rs1Value == rs2Value);
					3'b001: branchTaken = (rs1Value != rs2Value);
					3'b100: branchTaken = ($signed(rs1Value) < $signed(rs2Value));
					3'b101: branchTaken = ($signed(rs1Value) >= $signed(rs2Value));
					default: branchTaken = 1'b0;
				endcase
			end
			`OPC_JAL: begin
				aluA = pc;    // link address
				aluB = 64'd4;
				regWrite = 1'b1;
				branchTaken = 1'b1;
			end
			`OPC_SYSTEM: begin
				exitCall = (instr[31:7] == 25'd0) && (callValue == `EXIT_CALL);
			end
			default: ;
		endcase

		// frozen core issues nothing
		if (halted) begin
			regWrite = 1'b0;
			memRead = 1'b0;
			memWrite = 1'b0;
			branchTaken = 1'b0;
			exitCall = 1'b0;
		end
	end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regFile import cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  instr_t instr,
	input  logic   regWrite,
	input  logic   memRead,
	input  xlen_t  aluResult,
	input  xlen_t  loadData,
	output xlen_t  rs1Value,
	output xlen_t  rs2Value,
	output xlen_t  callValue
);

	xlen_t regs [`REG_COUNT];
	regIdx_t rs1;
	regIdx_t rs2;
	regIdx_t rd;
	xlen_t writeData;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign writeData = memRead ? loadData : aluResult;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= (i == 2) ? `SP_INIT : '0;    // x2 is the stack pointer
			end
		end else if (regWrite && rd != 5'd0) begin
			regs[rd] <= writeData;
		end
	end

	assign rs1Value = regs[rs1];
	assign rs2Value = regs[rs2];
	assign callValue = regs[17];    // a7 holds the call number

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu import cpuPkg::*; (
	input  xlen_t  a,
	input  xlen_t  b,
	input  aluOp_t op,
	output xlen_t  result
);

	logic [5:0] shamt;

	assign shamt = b[5:0];    // RV64 shift width

	always_comb begin
		case (op)
			`ALU_ADD:  result = a + b;
			`ALU_SUB:  result = a - b;
			`ALU_AND:  result = a & b;
			`ALU_OR:   result = a | b;
			`ALU_XOR:  result = a ^ b;
			`ALU_SLT:  result = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			`ALU_SLTU: result = (a < b) ? 64'd1 : 64'd0;
			`ALU_SLL:  result = a << shamt;
			`ALU_SRL:  result = a >> shamt;
			`ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
			default:   result = '0;
		endcase
	end

endmodule

/* src/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  instr_t instr,
	input  xlen_t  memReadData,
	output xlen_t  instrAddr,
	output xlen_t  memAddr,
	output xlen_t  memWriteData,
	output logic   memRead,
	output logic   memWrite,
	output logic   halted,
	output xlen_t  cycleCount
);

	xlen_t pc;
	xlen_t rs1Value;
	xlen_t rs2Value;
	xlen_t callValue;
	xlen_t aluA;
	xlen_t aluB;
	xlen_t aluResult;
	xlen_t branchTarget;
	aluOp_t aluOp;
	logic regWrite;
	logic branchTaken;
	logic exitCall;

	fetchControl fetch (
		.clk(clk),
		.rst(rst),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.exitCall(exitCall),
		.pc(pc),
		.halted(halted),
		.cycleCount(cycleCount)
	);

	instrDecoder decode (
		.instr(instr),
		.pc(pc),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.callValue(callValue),
		.halted(halted),
		.aluA(aluA),
		.aluB(aluB),
		.aluOp(aluOp),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.exitCall(exitCall)
	);

	regFile regs (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.regWrite(regWrite),
		.memRead(memRead),
		.aluResult(aluResult),
		.loadData(memReadData),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.callValue(callValue)
	);

	alu exec (
		.a(aluA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult)
	);

	assign instrAddr = pc;
	assign memAddr = aluResult;    // ld/sd effective address
	assign memWriteData = rs2Value;

endmodule

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
	input  logic resetReq,
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;    // 40 ns period
	end

	// ten cycles of reset at start and on each request
	always begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		@(posedge resetReq);
	end

endmodule

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb import cpuPkg::*; ();

	// five short programs and their resets stay far below this
	localparam int CYCLE_LIMIT = 2000;

	logic clk;
	logic rst;
	logic resetReq;
	instr_t instr;
	xlen_t memReadData;
	xlen_t instrAddr;
	xlen_t memAddr;
	xlen_t memWriteData;
	logic memRead;
	logic memWrite;
	logic halted;
	xlen_t cycleCount;

	instr_t instrMem [256];
	xlen_t dataMem [256];
	xlen_t readCycles;
	logic [7:0] progLen;
	logic [31:0] rngState = 32'h40a8eb0e;
	int errors = 0;
	int tests = 0;
	int cycles = 0;

	tbClock clkGen (.*);

	cpuCore dut (.*);

	assign instr = instrMem[instrAddr[9:2]];
	assign memReadData = dataMem[memAddr[10:3]];

	always @(posedge clk) begin
		if (memWrite && !rst) begin    // no stores while held in reset
			dataMem[memAddr[10:3]] = memWriteData;
		end
		if (memRead && !rst) begin
			readCycles++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, the programs did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// f73 is {funct7, funct3}
	function automatic instr_t rType(input logic [9:0] f73, input logic [4:0] rd, rs1, rs2);
		return {f73[9:3], rs2, rs1, f73[2:0], rd, 7'b0110011};
	endfunction

	function automatic instr_t iType(input logic [2:0] f3, input logic [4:0] rd, rs1,
			input logic [11:0] imm, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instr_t bType(input logic [2:0] f3, input logic [4:0] rs1, rs2,
			input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic emit(input instr_t word);
		instrMem[progLen] = word;
		progLen = progLen + 8'd1;
	endtask

	task automatic storeSlot(input logic [4:0] rs2, input logic [7:0] slot);
		logic [11:0] off;
		off = {1'b0, slot, 3'b000};
		emit({off[11:5], rs2, 5'd0, 3'b011, off[4:0], 7'b0100011});    // sd rs2, off(x0)
	endtask

	task automatic exitProgram();
		emit(iType(3'b000, 5'd17, 5'd0, 12'd93, 7'b0010011));
		emit(32'h00000073);
	endtask

	// lui then addi with RV64 sign extension of both immediates
	task automatic loadRandom(input logic [4:0] rd, output xlen_t value);
		logic [31:0] r;
		r = xorshift();
		emit({r[31:12], rd, 7'b0110111});
		emit(iType(3'b000, rd, rd, r[11:0], 7'b0010011));
		value = {{32{r[31]}}, r[31:12], 12'b0} + {{52{r[11]}}, r[11:0]};
	endtask

	task automatic newProgram();
		instrMem = '{default: '0};
		dataMem = '{default: '0};
		readCycles = '0;
		progLen = 8'd0;
	endtask

	task automatic runProgram();
		@(posedge clk);
		#1 resetReq = 1'b1;
		@(posedge clk);
		#1 resetReq = 1'b0;
		wait (!rst);
		wait (halted);
		#1;
	endtask

	task automatic checkValue(input string name, input xlen_t expected, input xlen_t actual);
		assert (actual === expected) else begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		tests++;
		$display("%s finished with %0d errors", name, errors - errBefore);
	endtask

	task automatic regOpsTest();
		logic [9:0] codes [10] = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004,
			10'h002, 10'h003, 10'h001, 10'h005, 10'h105};
		xlen_t a;
		xlen_t b;
		xlen_t expected;
		int errBefore;
		errBefore = errors;
		newProgram();
		loadRandom(5'd5, a);
		loadRandom(5'd6, b);
		for (int k = 0; k < 10; k++) begin
			emit(rType(codes[k], 5'd7, 5'd5, 5'd6));
			storeSlot(5'd7, 8'(k));
		end
		exitProgram();
		runProgram();
		for (int k = 0; k < 10; k++) begin
			case (k)
				0: expected = a + b;
				1: expected = a - b;
				2: expected = a & b;
				3: expected = a | b;
				4: expected = a ^ b;
				5: expected = {63'd0, $signed(a) < $signed(b)};
				6: expected = {63'd0, a < b};
				7: expected = a << b[5:0];
				8: expected = a >> b[5:0];
				9: expected = $signed(a) >>> b[5:0];
				default: expected = '0;
			endcase
			checkValue("regOps", expected, dataMem[8'(k)]);
		end
		reportTest("regOps", errBefore);
	endtask

	task automatic immOpsTest();
		logic [2:0] funct3s [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
		logic [11:0] imms [5];
		xlen_t a;
		xlen_t imm64;
		xlen_t expected;
		int errBefore;
		errBefore = errors;
		newProgram();
		loadRandom(5'd5, a);
		for (int k = 0; k < 5; k++) begin
			imms[k] = 12'(xorshift()) | ((k == 0) ? 12'h800 : 12'h000);    // first one negative
			emit(iType(funct3s[k], 5'd8, 5'd5, imms[k], 7'b0010011));
			storeSlot(5'd8, 8'(k));
		end
		exitProgram();
		runProgram();
		for (int k = 0; k < 5; k++) begin
			imm64 = {{52{imms[k][11]}}, imms[k]};
			case (k)
				0: expected = a + imm64;
				1: expected = a & imm64;
				2: expected = a | imm64;
				3: expected = a ^ imm64;
				default: expected = {63'd0, $signed(a) < $signed(imm64)};
			endcase
			checkValue("immOps", expected, dataMem[8'(k)]);
		end
		reportTest("immOps", errBefore);
	endtask

	task automatic loadStoreTest();
		xlen_t stored;
		int errBefore;
		errBefore = errors;
		newProgram();
		stored = {xorshift(), xorshift()};
		dataMem[20] = stored;
		dataMem[23] = '1;    // zero has to overwrite this
		emit(iType(3'b011, 5'd9, 5'd0, 12'd160, 7'b0000011));    // ld x9, 160(x0)
		storeSlot(5'd9, 8'd21);
		storeSlot(5'd2, 8'd22);
		emit(iType(3'b000, 5'd0, 5'd0, 12'h055, 7'b0010011));    // addi x0, x0, 0x55
		storeSlot(5'd0, 8'd23);
		exitProgram();
		runProgram();
		checkValue("loadStore", stored, dataMem[21]);
		checkValue("loadStore", `SP_INIT, dataMem[22]);
		checkValue("loadStore", 64'd0, dataMem[23]);
		checkValue("loadStore", 64'd1, readCycles);    // one ld, one read cycle
		reportTest("loadStore", errBefore);
	endtask

	task automatic branchTest();
		logic [2:0] funct3s [8] = '{3'b000, 3'b000, 3'b001, 3'b001, 3'b100, 3'b100, 3'b101, 3'b101};
		logic [4:0] lhs [8] = '{5'd5, 5'd5, 5'd5, 5'd5, 5'd5, 5'd6, 5'd6, 5'd5};
		logic [4:0] rhs [8] = '{5'd7, 5'd6, 5'd6, 5'd7, 5'd6, 5'd5, 5'd5, 5'd6};
		logic [7:0] jalAt;
		int errBefore;
		errBefore = errors;
		newProgram();
		emit(iType(3'b000, 5'd5, 5'd0, 12'hffd, 7'b0010011));    // x5 = -3
		emit(iType(3'b000, 5'd6, 5'd0, 12'd4, 7'b0010011));
		emit(iType(3'b000, 5'd7, 5'd0, 12'hffd, 7'b0010011));
		emit(iType(3'b000, 5'd10, 5'd0, 12'h5a5, 7'b0010011));    // marker
		for (int k = 0; k < 8; k++) begin
			emit(bType(funct3s[k], lhs[k], rhs[k], 13'd8));    // taken skips the store
			storeSlot(5'd10, 8'(k));
		end
		jalAt = progLen;
		emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd11, 7'b1101111});    // jal x11, +8
		storeSlot(5'd10, 8'd8);
		storeSlot(5'd11, 8'd9);
		exitProgram();
		runProgram();
		// -3 == -3, -3 != 4, -3 < 4 and 4 >= -3 make every even case taken
		for (int k = 0; k < 8; k++) begin
			checkValue("branch", (k % 2 == 0) ? 64'd0 : 64'h5a5, dataMem[8'(k)]);
		end
		checkValue("branch", 64'd0, dataMem[8]);
		checkValue("branch", {54'd0, jalAt, 2'b00} + 64'd4, dataMem[9]);
		reportTest("branch", errBefore);
	endtask

	task automatic haltTest();
		xlen_t exitPc;
		xlen_t expectedLen;
		int errBefore;
		errBefore = errors;
		newProgram();
		emit(iType(3'b000, 5'd17, 5'd0, 12'd5, 7'b0010011));
		emit(32'h00000073);    // call number 5 keeps running
		emit(iType(3'b000, 5'd10, 5'd0, 12'd77, 7'b0010011));
		storeSlot(5'd10, 8'd0);
		exitProgram();
		expectedLen = {56'd0, progLen};
		exitPc = {54'd0, progLen, 2'b00};    // word after the exit ecall
		storeSlot(5'd10, 8'd1);    // behind the exit
		runProgram();
		checkValue("halt", 64'd77, dataMem[0]);
		checkValue("halt", 64'd0, dataMem[1]);
		checkValue("halt", expectedLen, cycleCount);
		checkValue("halt", exitPc, instrAddr);
		repeat (3) @(posedge clk);
		#1;
		checkValue("halt", expectedLen, cycleCount);
		checkValue("halt", exitPc, instrAddr);
		assert (halted) else begin
			$display("halt: the core left the halted state without a reset");
			errors++;
		end
		reportTest("halt", errBefore);
	endtask

	initial begin
		resetReq = 1'b0;
		newProgram();
		regOpsTest();
		immOpsTest();
		loadStoreTest();
		branchTest();
		haltTest();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+src
src/cpuPkg.sv
src/fetchControl.sv
src/instrDecoder.sv
src/regFile.sv
src/alu.sv
src/cpuCore.sv
sim/tbClock.sv
sim/cpuTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = cpuTb
FILELIST  = files.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG)
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
